// ==== core_pkg.sv ====
package core_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int NUM_REGS       = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int MEM_WORDS      = 64;
  localparam int MEM_ADDR_WIDTH = 6;

  // instruction fields
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int SHAMT_MSB  = 10;
  localparam int SHAMT_LSB  = 6;
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  typedef logic [DATA_WIDTH-1:0]          data_t;
  typedef logic [DATA_WIDTH-1:0]          inst_t;
  typedef logic [REG_ADDR_WIDTH-1:0]      reg_addr_t;
  typedef logic [IMM_MSB-IMM_LSB:0]       imm_t;
  typedef logic [SHAMT_MSB-SHAMT_LSB:0]   shamt_t;
  typedef logic [MEM_ADDR_WIDTH-1:0]      mem_addr_t;

  // anything not listed decodes as a nop
  typedef enum logic [OPCODE_MSB-OPCODE_LSB:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_XOR  = 6'd5,
    OP_SLT  = 6'd6,
    OP_SLL  = 6'd7,
    OP_ADDI = 6'd8,
    OP_LW   = 6'd9,
    OP_SW   = 6'd10
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL
  } alu_op_e;

endpackage

// ==== opcode_decoder.sv ====
`timescale 1ns/100ps

module opcode_decoder
  import core_pkg::*;
(
  input  opcode_e opcode,
  output alu_op_e alu_op,
  output logic    use_imm,
  output logic    dest_is_rd,
  output logic    writes_reg,
  output logic    is_load,
  output logic    is_store
);

  // alu operation, memory ops and addi reuse the adder
  always_comb begin
    case (opcode)
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_XOR:  alu_op = ALU_XOR;
      OP_SLT:  alu_op = ALU_SLT;
      OP_SLL:  alu_op = ALU_SLL;
      default: alu_op = ALU_ADD;
    endcase
  end

  // control flags
  always_comb begin
    use_imm    = 1'b0;
    dest_is_rd = 1'b0;
    writes_reg = 1'b0;
    is_load    = 1'b0;
    is_store   = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL: begin
        dest_is_rd = 1'b1;
        writes_reg = 1'b1;
      end
      OP_ADDI: begin
        use_imm    = 1'b1;
        writes_reg = 1'b1;
      end
      OP_LW: begin
        use_imm    = 1'b1;
        writes_reg = 1'b1;
        is_load    = 1'b1;
      end
      OP_SW: begin
        use_imm  = 1'b1;
        is_store = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu
  import core_pkg::*;
(
  input  alu_op_e alu_op,
  input  data_t   a,
  input  data_t   b,
  input  shamt_t  shamt,
  output data_t   result
);

  logic a_lt_b;

  // signed compare for slt
  assign a_lt_b = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = data_t'(a_lt_b);
      // shift operand comes from rt
      ALU_SLL: result = b << shamt;
      default: result = '0;
    endcase
  end

endmodule

// ==== alu_lane.sv ====
`timescale 1ns/100ps

module alu_lane
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      issue_valid,
  input  inst_t     inst,
  input  data_t     rs_data,
  input  data_t     rt_data,
  input  logic      peer_res_valid,
  input  reg_addr_t peer_res_dest,
  input  data_t     peer_res_data,
  output logic      res_valid,
  output reg_addr_t res_dest,
  output data_t     res_data
);

  logic      ex_valid;
  inst_t     ex_inst;
  data_t     ex_rs_data;
  data_t     ex_rt_data;
  reg_addr_t ex_rs;
  reg_addr_t ex_rt;
  reg_addr_t ex_rd;
  alu_op_e   alu_op;
  logic      use_imm;
  logic      dest_is_rd;
  logic      writes_reg;
  logic      is_load;
  logic      is_store;
  data_t     fwd_a;
  data_t     fwd_b;
  data_t     alu_result;
  reg_addr_t dest;
  logic      wb_en;

  //////////////////////////////////////////////////////////////////////
  // issue register

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    ex_inst    <= inst;
    ex_rs_data <= rs_data;
    ex_rt_data <= rt_data;
  end

  assign ex_rs = ex_inst[RS_MSB:RS_LSB];
  assign ex_rt = ex_inst[RT_MSB:RT_LSB];
  assign ex_rd = ex_inst[RD_MSB:RD_LSB];

  //////////////////////////////////////////////////////////////////////
  // execute

  opcode_decoder decoder_i (
    .opcode     (opcode_e'(ex_inst[OPCODE_MSB:OPCODE_LSB])),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .dest_is_rd (dest_is_rd),
    .writes_reg (writes_reg),
    .is_load    (is_load),
    .is_store   (is_store)
  );

  // lane 1 is younger, so its result wins over ours
  always_comb begin
    if (peer_res_valid && peer_res_dest == ex_rs) begin
      fwd_a = peer_res_data;
    end else if (res_valid && res_dest == ex_rs) begin
      fwd_a = res_data;
    end else begin
      fwd_a = ex_rs_data;
    end
    if (peer_res_valid && peer_res_dest == ex_rt) begin
      fwd_b = peer_res_data;
    end else if (res_valid && res_dest == ex_rt) begin
      fwd_b = res_data;
    end else begin
      fwd_b = ex_rt_data;
    end
  end

  alu alu_i (
    .alu_op (alu_op),
    .a      (fwd_a),
    .b      (use_imm ? data_t'(imm_t'(ex_inst[IMM_MSB:IMM_LSB])) : fwd_b),
    .shamt  (shamt_t'(ex_inst[SHAMT_MSB:SHAMT_LSB])),
    .result (alu_result)
  );

  assign dest = dest_is_rd ? ex_rd : ex_rt;

  // no memory port here, loads and stores fall through as nops
  assign wb_en = ex_valid && writes_reg && !(is_load || is_store) && dest != '0;

  //////////////////////////////////////////////////////////////////////
  // writeback register

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= wb_en;
    end
  end

  always_ff @(posedge clk) begin
    res_dest <= dest;
    res_data <= alu_result;
  end

endmodule

// ==== mem_lane.sv ====
`timescale 1ns/100ps

module mem_lane
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      issue_valid,
  input  inst_t     inst,
  input  data_t     rs_data,
  input  data_t     rt_data,
  input  logic      peer_res_valid,
  input  reg_addr_t peer_res_dest,
  input  data_t     peer_res_data,
  output logic      res_valid,
  output reg_addr_t res_dest,
  output data_t     res_data
);

  logic      ex_valid;
  inst_t     ex_inst;
  data_t     ex_rs_data;
  data_t     ex_rt_data;
  reg_addr_t ex_rs;
  reg_addr_t ex_rt;
  reg_addr_t ex_rd;
  alu_op_e   alu_op;
  logic      use_imm;
  logic      dest_is_rd;
  logic      writes_reg;
  logic      is_load;
  logic      is_store;
  data_t     fwd_a;
  data_t     fwd_b;
  data_t     alu_result;
  reg_addr_t dest;
  logic      wb_en;
  mem_addr_t mem_addr;
  data_t     load_data;
  data_t     mem [MEM_WORDS];

  //////////////////////////////////////////////////////////////////////
  // issue register

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    ex_inst    <= inst;
    ex_rs_data <= rs_data;
    ex_rt_data <= rt_data;
  end

  assign ex_rs = ex_inst[RS_MSB:RS_LSB];
  assign ex_rt = ex_inst[RT_MSB:RT_LSB];
  assign ex_rd = ex_inst[RD_MSB:RD_LSB];

  //////////////////////////////////////////////////////////////////////
  // execute

  opcode_decoder decoder_i (
    .opcode     (opcode_e'(ex_inst[OPCODE_MSB:OPCODE_LSB])),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .dest_is_rd (dest_is_rd),
    .writes_reg (writes_reg),
    .is_load    (is_load),
    .is_store   (is_store)
  );

  // own result first, lane 0 was the older writer
  always_comb begin
    if (res_valid && res_dest == ex_rs) begin
      fwd_a = res_data;
    end else if (peer_res_valid && peer_res_dest == ex_rs) begin
      fwd_a = peer_res_data;
    end else begin
      fwd_a = ex_rs_data;
    end
    if (res_valid && res_dest == ex_rt) begin
      fwd_b = res_data;
    end else if (peer_res_valid && peer_res_dest == ex_rt) begin
      fwd_b = peer_res_data;
    end else begin
      fwd_b = ex_rt_data;
    end
  end

  alu alu_i (
    .alu_op (alu_op),
    .a      (fwd_a),
    .b      (use_imm ? data_t'(imm_t'(ex_inst[IMM_MSB:IMM_LSB])) : fwd_b),
    .shamt  (shamt_t'(ex_inst[SHAMT_MSB:SHAMT_LSB])),
    .result (alu_result)
  );

  assign dest  = dest_is_rd ? ex_rd : ex_rt;
  assign wb_en = ex_valid && writes_reg && dest != '0;

  // word index from the low bits of rs + imm
  assign mem_addr  = alu_result[MEM_ADDR_WIDTH-1:0];
  assign load_data = mem[mem_addr];

  // store data is the forwarded rt, not the immediate
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (ex_valid && is_store) begin
      mem[mem_addr] <= fwd_b;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // writeback register

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= wb_en;
    end
  end

  always_ff @(posedge clk) begin
    res_dest <= dest;
    res_data <= is_load ? load_data : alu_result;
  end

endmodule

// ==== register_file.sv ====
`timescale 1ns/100ps

module register_file
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rd_addr0a,
  input  reg_addr_t rd_addr0b,
  input  reg_addr_t rd_addr1a,
  input  reg_addr_t rd_addr1b,
  input  logic      wr_en0,
  input  logic      wr_en1,
  input  reg_addr_t wr_addr0,
  input  reg_addr_t wr_addr1,
  input  data_t     wr_data0,
  input  data_t     wr_data1,
  output data_t     rd_data0a,
  output data_t     rd_data0b,
  output data_t     rd_data1a,
  output data_t     rd_data1b
);

  data_t regs [NUM_REGS];

  // write-through read with lane 1 checked first
  assign rd_data0a = (rd_addr0a == '0) ? '0 :
                     (wr_en1 && wr_addr1 == rd_addr0a) ? wr_data1 :
                     (wr_en0 && wr_addr0 == rd_addr0a) ? wr_data0 :
                     regs[rd_addr0a];
  assign rd_data0b = (rd_addr0b == '0) ? '0 :
                     (wr_en1 && wr_addr1 == rd_addr0b) ? wr_data1 :
                     (wr_en0 && wr_addr0 == rd_addr0b) ? wr_data0 :
                     regs[rd_addr0b];
  assign rd_data1a = (rd_addr1a == '0) ? '0 :
                     (wr_en1 && wr_addr1 == rd_addr1a) ? wr_data1 :
                     (wr_en0 && wr_addr0 == rd_addr1a) ? wr_data0 :
                     regs[rd_addr1a];
  assign rd_data1b = (rd_addr1b == '0) ? '0 :
                     (wr_en1 && wr_addr1 == rd_addr1b) ? wr_data1 :
                     (wr_en0 && wr_addr0 == rd_addr1b) ? wr_data0 :
                     regs[rd_addr1b];

  // lane 1 write comes last so it wins on an equal address
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_en0 && wr_addr0 != '0) begin
        regs[wr_addr0] <= wr_data0;
      end
      if (wr_en1 && wr_addr1 != '0) begin
        regs[wr_addr1] <= wr_data1;
      end
    end
  end

endmodule

// ==== dual_issue_core.sv ====
`timescale 1ns/100ps

module dual_issue_core
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      issue_valid,
  input  inst_t     inst0,
  input  inst_t     inst1,
  output logic      wb_valid0,
  output logic      wb_valid1,
  output reg_addr_t wb_dest0,
  output reg_addr_t wb_dest1,
  output data_t     wb_data0,
  output data_t     wb_data1
);

  data_t rs_data0;
  data_t rt_data0;
  data_t rs_data1;
  data_t rt_data1;

  //////////////////////////////////////////////////////////////////////
  // shared register file, written from both writeback registers

  register_file regfile_i (
    .clk       (clk),
    .rst       (rst),
    .rd_addr0a (inst0[RS_MSB:RS_LSB]),
    .rd_addr0b (inst0[RT_MSB:RT_LSB]),
    .rd_addr1a (inst1[RS_MSB:RS_LSB]),
    .rd_addr1b (inst1[RT_MSB:RT_LSB]),
    .wr_en0    (wb_valid0),
    .wr_en1    (wb_valid1),
    .wr_addr0  (wb_dest0),
    .wr_addr1  (wb_dest1),
    .wr_data0  (wb_data0),
    .wr_data1  (wb_data1),
    .rd_data0a (rs_data0),
    .rd_data0b (rt_data0),
    .rd_data1a (rs_data1),
    .rd_data1b (rt_data1)
  );

  //////////////////////////////////////////////////////////////////////
  // lanes, each forwards from the other's writeback register

  alu_lane lane0_i (
    .clk            (clk),
    .rst            (rst),
    .issue_valid    (issue_valid),
    .inst           (inst0),
    .rs_data        (rs_data0),
    .rt_data        (rt_data0),
    .peer_res_valid (wb_valid1),
    .peer_res_dest  (wb_dest1),
    .peer_res_data  (wb_data1),
    .res_valid      (wb_valid0),
    .res_dest       (wb_dest0),
    .res_data       (wb_data0)
  );

  // lane 1 owns the data memory
  mem_lane lane1_i (
    .clk            (clk),
    .rst            (rst),
    .issue_valid    (issue_valid),
    .inst           (inst1),
    .rs_data        (rs_data1),
    .rt_data        (rt_data1),
    .peer_res_valid (wb_valid0),
    .peer_res_dest  (wb_dest0),
    .peer_res_data  (wb_data0),
    .res_valid      (wb_valid1),
    .res_dest       (wb_dest1),
    .res_data       (wb_data1)
  );

endmodule

// ==== tb_dual_issue_core.sv ====
`timescale 1ns/100ps

module tb_dual_issue_core
  import core_pkg::*;
;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 8;
  localparam int IDLE_CYCLES   = 2;
  localparam int NUM_PAIRS     = 400;
  localparam int WATCHDOG_TIME = (NUM_PAIRS + 20) * CLK_PERIOD;

  logic      clk;
  logic      rst;
  logic      issue_valid;
  inst_t     inst0;
  inst_t     inst1;
  logic      wb_valid0;
  logic      wb_valid1;
  reg_addr_t wb_dest0;
  reg_addr_t wb_dest1;
  data_t     wb_data0;
  data_t     wb_data1;

  logic [31:0] rand_state;
  data_t       model_regs [NUM_REGS];
  data_t       model_mem [MEM_WORDS];

  // expected writeback per slot ([0] issued last cycle and [1] the cycle before)
  logic      exp_valid0 [2];
  logic      exp_valid1 [2];
  reg_addr_t exp_dest0 [2];
  reg_addr_t exp_dest1 [2];
  data_t     exp_data0 [2];
  data_t     exp_data1 [2];

  dual_issue_core dut_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .inst0       (inst0),
    .inst1       (inst1),
    .wb_valid0   (wb_valid0),
    .wb_valid1   (wb_valid1),
    .wb_dest0    (wb_dest0),
    .wb_dest1    (wb_dest1),
    .wb_data0    (wb_data0),
    .wb_data1    (wb_data1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout at %0t, the test did not reach its end", $time);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus

  function automatic logic [15:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state[31:16];
  endfunction

  // small register numbers so that pairs depend on each other
  function automatic inst_t make_inst();
    logic [15:0] r0;
    logic [15:0] r1;
    logic [5:0]  op;
    inst_t       inst;
    r0 = next_rand();
    r1 = next_rand();
    if (r0[3:0] == 4'd0) begin
      op = 6'(11 + (r0[9:4] % 53));
    end else begin
      op = 6'(r0[9:4] % 11);
    end
    inst = '0;
    inst[OPCODE_MSB:OPCODE_LSB] = op;
    inst[RS_LSB +: 3] = r0[12:10];
    inst[RT_LSB +: 3] = r0[15:13];
    if (op == OP_ADDI || op == OP_LW || op == OP_SW) begin
      inst[IMM_LSB +: 4] = r1[3:0];
      // now and then a top bit to see the zero extension
      inst[IMM_MSB] = (r1[15:12] == 4'd0);
      // base register 0 half the time keeps the word index low
      if ((op == OP_LW || op == OP_SW) && r1[4]) begin
        inst[RS_MSB:RS_LSB] = '0;
      end
    end else begin
      inst[RD_LSB +: 3] = r1[2:0];
      inst[SHAMT_MSB:SHAMT_LSB] = r1[7:3];
      inst[5:0] = r1[13:8];
    end
    return inst;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model

  task automatic model_lane(input inst_t inst, input logic has_mem, output logic valid,
                            output reg_addr_t dest, output data_t value);
    logic [5:0] op;
    shamt_t     sh;
    data_t      imm;
    data_t      a;
    data_t      b;
    data_t      addr;
    op    = inst[OPCODE_MSB:OPCODE_LSB];
    sh    = inst[SHAMT_MSB:SHAMT_LSB];
    imm   = {16'b0, inst[IMM_MSB:IMM_LSB]};
    a     = model_regs[inst[RS_MSB:RS_LSB]];
    b     = model_regs[inst[RT_MSB:RT_LSB]];
    addr  = a + imm;
    valid = 1'b1;
    dest  = inst[RD_MSB:RD_LSB];
    value = '0;
    case (op)
      OP_ADD: value = a + b;
      OP_SUB: value = a - b;
      OP_AND: value = a & b;
      OP_OR:  value = a | b;
      OP_XOR: value = a ^ b;
      OP_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLL: value = b << sh;
      OP_ADDI: begin
        dest  = inst[RT_MSB:RT_LSB];
        value = a + imm;
      end
      OP_LW: begin
        dest  = inst[RT_MSB:RT_LSB];
        valid = has_mem;
        value = model_mem[addr[MEM_ADDR_WIDTH-1:0]];
      end
      OP_SW: begin
        valid = 1'b0;
        if (has_mem) begin
          model_mem[addr[MEM_ADDR_WIDTH-1:0]] = b;
        end
      end
      default: valid = 1'b0;
    endcase
    if (dest == '0) begin
      valid = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checking

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
      $display("Regression failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // drive a pair and check the pair from two edges back
  task automatic run_cycle(input logic allow_issue);
    logic [15:0] r;
    logic        v;
    inst_t       i0;
    inst_t       i1;
    logic        v0;
    logic        v1;
    reg_addr_t   d0;
    reg_addr_t   d1;
    data_t       x0;
    data_t       x1;
    @(posedge clk);
    r  = next_rand();
    v  = allow_issue && (r[2:0] != 3'd0);
    i0 = make_inst();
    i1 = make_inst();
    issue_valid <= v;
    inst0       <= i0;
    inst1       <= i1;
    v0 = 1'b0;
    v1 = 1'b0;
    d0 = '0;
    d1 = '0;
    x0 = '0;
    x1 = '0;
    if (v) begin
      // both lanes read the state from before the pair
      model_lane(i0, 1'b0, v0, d0, x0);
      model_lane(i1, 1'b1, v1, d1, x1);
      if (v0) begin
        model_regs[d0] = x0;
      end
      if (v1) begin
        model_regs[d1] = x1;
      end
    end
    @(negedge clk);
    check_value("wb_valid0", 32'(wb_valid0), 32'(exp_valid0[1]));
    check_value("wb_valid1", 32'(wb_valid1), 32'(exp_valid1[1]));
    if (exp_valid0[1]) begin
      check_value("wb_dest0", 32'(wb_dest0), 32'(exp_dest0[1]));
      check_value("wb_data0", wb_data0, exp_data0[1]);
    end
    if (exp_valid1[1]) begin
      check_value("wb_dest1", 32'(wb_dest1), 32'(exp_dest1[1]));
      check_value("wb_data1", wb_data1, exp_data1[1]);
    end
    exp_valid0[1] = exp_valid0[0];
    exp_valid1[1] = exp_valid1[0];
    exp_dest0[1]  = exp_dest0[0];
    exp_dest1[1]  = exp_dest1[0];
    exp_data0[1]  = exp_data0[0];
    exp_data1[1]  = exp_data1[0];
    exp_valid0[0] = v0;
    exp_valid1[0] = v1;
    exp_dest0[0]  = d0;
    exp_dest1[0]  = d1;
    exp_data0[0]  = x0;
    exp_data1[0]  = x1;
  endtask

  initial begin
    rand_state  = 32'd27;
    rst         = 1'b1;
    issue_valid = 1'b0;
    inst0       = '0;
    inst1       = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    for (int i = 0; i < 2; i++) begin
      exp_valid0[i] = 1'b0;
      exp_valid1[i] = 1'b0;
      exp_dest0[i]  = '0;
      exp_dest1[i]  = '0;
      exp_data0[i]  = '0;
      exp_data1[i]  = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    // quiet cycles first with no writeback expected
    repeat (IDLE_CYCLES) run_cycle(1'b0);
    repeat (NUM_PAIRS) run_cycle(1'b1);
    // drain the last two pairs
    repeat (2) run_cycle(1'b0);
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
core_pkg.sv
opcode_decoder.sv
alu.sv
alu_lane.sv
mem_lane.sv
register_file.sv
dual_issue_core.sv
tb_dual_issue_core.sv
